// ==== itf_top.f ====
itf_cfg_pkg.sv
itf_state_pkg.sv
fifo_async_fwft.sv
off_link_ctrl.sv
core_link_ctrl.sv
itf_top.sv
itf_top_chk.sv
tb_itf_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Verilator build and run of the link bridge testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_itf_top -f itf_top.f -o sim_itf_top

# Keep running past assertion failures so the testbench prints its result
./obj_dir/sim_itf_top +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== itf_patterns.txt ====
// dir flag len first_word, one packet per line, all hex
// dir 0 off chip to core (flag = instruction), 1 GIC out (flag = command), 2 MON out
// dir ff ends the list
0 1 4 a5000000000000000000000000001000
0 0 3 5a000000000000000000000000002000
1 1 5 c3000000000000000000000000003000
2 0 4 3c000000000000000000000000004000
0 1 12 f0000000000000000000000000005000
1 0 2 0f000000000000000000000000006000
0 0 1 81000000000000000000000000007000
2 1 3 18000000000000000000000000008000
1 1 11 e7000000000000000000000000009000
0 0 6 7e00000000000000000000000000a000
2 0 1 9900000000000000000000000000b000
0 1 2 6600000000000000000000000000c000
1 0 3 bd00000000000000000000000000d000
ff 0 0 0

// ==== tb_itf_top.sv ====
// --------------------
// Link bridge testbench, pattern replay, scoreboards, watchdog
// --------------------
module tb_itf_top
    import itf_cfg_pkg::*;
();

    localparam int MAX_PAT    = 16;
    localparam int RACE_BEATS = 7;
    localparam int BP_BEATS   = 20;

    logic             OffClk = 1'b0;
    logic             clk = 1'b0;
    logic             rst_n;
    // Off chip port
    logic             off_dat_vld_i, off_dat_last_i, off_isa_i, off_dat_rdy_i;
    logic [DAT_W-1:0] off_dat_i;
    logic             off_dat_rdy_o, off_dat_vld_o, off_dat_last_o, off_cmd_o, off_oe_o;
    logic [DAT_W-1:0] off_dat_o;
    // Core ports
    logic [DAT_W-1:0] ccu_dat_o, gic_out_dat_o, gic_in_dat_i, mon_dat_i;
    logic             ccu_vld_o, ccu_last_o, ccu_rdy_i;
    logic             gic_out_vld_o, gic_out_last_o, gic_out_rdy_i;
    logic             gic_in_vld_i, gic_in_last_i, gic_in_cmd_i, gic_in_rdy_o;
    logic             mon_vld_i, mon_last_i, mon_rdy_o;

    // Four words per packet
    logic [DAT_W-1:0] pat_mem [4*MAX_PAT];
    int               n_pat;
    int               pat_beats;

    // Expected beats, {data, flag, last}
    logic [BEAT_W-1:0] exp_ccu [$];
    logic [BEAT_W-1:0] exp_gic [$];
    logic [BEAT_W-1:0] exp_off [$];

    integer seed = 21;
    logic   rdy_random = 1'b0;
    logic   off_rdy_en = 1'b1;
    int     wd_cycles = 0;
    string  cur_test = "reset";
    int     test_err = 0;
    int     total_err = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    always #5 OffClk = ~OffClk;
    always #7 clk = ~clk;

    itf_top u_itf_top (.*);

    // --------------------
    // Ready generators, random gaps when enabled
    always @(negedge OffClk) begin
        if (!off_rdy_en) begin
            off_dat_rdy_i = 1'b0;
        end else begin
            off_dat_rdy_i = rdy_random ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    always @(negedge clk) begin
        ccu_rdy_i     = rdy_random ? (($random(seed) & 3) != 0) : 1'b1;
        gic_out_rdy_i = rdy_random ? (($random(seed) & 3) != 0) : 1'b1;
    end

    task automatic check_val(input string name, input logic [BEAT_W-1:0] exp_v,
                             input logic [BEAT_W-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected %h actual %h", name, exp_v, act_v);
            test_err++;
        end
    endtask

    task automatic report_extra(input string port);
        $display("Beat on %s port with nothing expected in test %s", port, cur_test);
        test_err++;
    endtask

    // --------------------
    // Scoreboards, sampled at the handshake edge
    always @(posedge clk) begin
        if (rst_n && ccu_vld_o && ccu_rdy_i) begin
            if (exp_ccu.size() == 0) begin
                report_extra("CCU");
            end else begin
                check_val({cur_test, "/ccu"}, exp_ccu.pop_front(), {ccu_dat_o, 1'b0, ccu_last_o});
            end
        end
        if (rst_n && gic_out_vld_o && gic_out_rdy_i) begin
            if (exp_gic.size() == 0) begin
                report_extra("GIC");
            end else begin
                check_val({cur_test, "/gic"}, exp_gic.pop_front(),
                          {gic_out_dat_o, 1'b0, gic_out_last_o});
            end
        end
    end

    always @(posedge OffClk) begin
        if (rst_n && off_dat_vld_o && off_dat_rdy_i) begin
            if (exp_off.size() == 0) begin
                report_extra("off chip");
            end else begin
                check_val({cur_test, "/off"}, exp_off.pop_front(),
                          {off_dat_o, off_cmd_o, off_dat_last_o});
            end
        end
    end

    // Dir 0 inbound, 1 GIC out, 2 MON out; beat k carries first + k
    task automatic expect_pkt(input int dir, input logic flag, input int len,
                              input logic [DAT_W-1:0] first);
        int k;
        for (k = 0; k < len; k++) begin
            if (dir == 0 && flag) begin
                exp_ccu.push_back({first + DAT_W'(k), 1'b0, k == len - 1});
            end else if (dir == 0) begin
                exp_gic.push_back({first + DAT_W'(k), 1'b0, k == len - 1});
            end else begin
                // MON never carries a command
                exp_off.push_back({first + DAT_W'(k), (dir == 1) & flag, k == len - 1});
            end
        end
    endtask

    // --------------------
    // Source drivers, valid held until taken
    task automatic send_off(input logic flag, input int len, input logic [DAT_W-1:0] first);
        int k;
        for (k = 0; k < len; k++) begin
            @(negedge OffClk);
            off_dat_vld_i  = 1'b1;
            off_dat_last_i = (k == len - 1);
            off_isa_i      = flag;
            off_dat_i      = first + DAT_W'(k);
            @(posedge OffClk);
            while (!off_dat_rdy_o) begin
                @(posedge OffClk);
            end
        end
        @(negedge OffClk);
        off_dat_vld_i  = 1'b0;
        off_dat_last_i = 1'b0;
    endtask

    task automatic send_gic(input logic cmd, input int len, input logic [DAT_W-1:0] first);
        int k;
        for (k = 0; k < len; k++) begin
            @(negedge clk);
            gic_in_vld_i  = 1'b1;
            gic_in_last_i = (k == len - 1);
            gic_in_cmd_i  = cmd;
            gic_in_dat_i  = first + DAT_W'(k);
            @(posedge clk);
            while (!gic_in_rdy_o) begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        gic_in_vld_i  = 1'b0;
        gic_in_last_i = 1'b0;
    endtask

    task automatic send_mon(input int len, input logic [DAT_W-1:0] first);
        int k;
        for (k = 0; k < len; k++) begin
            @(negedge clk);
            mon_vld_i  = 1'b1;
            mon_last_i = (k == len - 1);
            mon_dat_i  = first + DAT_W'(k);
            @(posedge clk);
            while (!mon_rdy_o) begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        mon_vld_i  = 1'b0;
        mon_last_i = 1'b0;
    endtask

    // One packet at a time, in file order
    task automatic run_patterns();
        int i;
        int dir;
        int len;
        for (i = 0; i < n_pat; i++) begin
            dir = int'(pat_mem[4*i]);
            len = int'(pat_mem[4*i+2]);
            expect_pkt(dir, pat_mem[4*i+1][0], len, pat_mem[4*i+3]);
            case (dir)
                0: send_off(pat_mem[4*i+1][0], len, pat_mem[4*i+3]);
                1: send_gic(pat_mem[4*i+1][0], len, pat_mem[4*i+3]);
                default: send_mon(len, pat_mem[4*i+3]);
            endcase
        end
    endtask

    task automatic wait_drain();
        while (exp_ccu.size() + exp_gic.size() + exp_off.size() != 0) begin
            @(posedge clk);
        end
        // Catch stray beats
        repeat (6) @(posedge clk);
    endtask

    task automatic finish_test();
        tests_run++;
        total_err += test_err;
        if (test_err == 0) begin
            $display("Test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", cur_test, test_err);
        end
        test_err = 0;
    endtask

    // --------------------
    // Watchdog, 200 core cycles per beat
    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout, the run did not finish within %0d core clock cycles", wd_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        off_dat_vld_i  = 1'b0;
        off_dat_last_i = 1'b0;
        off_isa_i      = 1'b0;
        off_dat_i      = '0;
        off_dat_rdy_i  = 1'b0;
        ccu_rdy_i      = 1'b0;
        gic_out_rdy_i  = 1'b0;
        gic_in_dat_i   = '0;
        gic_in_vld_i   = 1'b0;
        gic_in_last_i  = 1'b0;
        gic_in_cmd_i   = 1'b0;
        mon_dat_i      = '0;
        mon_vld_i      = 1'b0;
        mon_last_i     = 1'b0;
        $readmemh("itf_patterns.txt", pat_mem);
        n_pat     = 0;
        pat_beats = 0;
        while (n_pat < MAX_PAT && pat_mem[4*n_pat] != 'hff) begin
            pat_beats += int'(pat_mem[4*n_pat+2]);
            n_pat++;
        end
        // Two pattern passes plus race and back-pressure packets
        wd_cycles = 200 * (2 * pat_beats + RACE_BEATS + BP_BEATS);
        repeat (8) @(posedge OffClk);
        @(negedge OffClk);
        rst_n = 1'b1;

        cur_test = "reset_values";
        repeat (3) @(negedge clk);
        check_val(cur_test, '0, BEAT_W'({off_dat_rdy_o, off_dat_vld_o, off_oe_o, ccu_vld_o,
                                         gic_out_vld_o, gic_in_rdy_o, mon_rdy_o}));
        finish_test();

        cur_test = "patterns_steady";
        run_patterns();
        wait_drain();
        finish_test();

        // Same-cycle start, MON packet goes first
        cur_test = "mon_before_gic";
        expect_pkt(2, 1'b0, 3, 128'h44000000000000000000000000000100);
        expect_pkt(1, 1'b1, 4, 128'h55000000000000000000000000000200);
        fork
            send_mon(3, 128'h44000000000000000000000000000100);
            send_gic(1'b1, 4, 128'h55000000000000000000000000000200);
        join
        wait_drain();
        finish_test();

        // Off chip stalls long enough to fill the outbound FIFO
        cur_test = "off_backpressure";
        off_rdy_en = 1'b0;
        expect_pkt(1, 1'b0, BP_BEATS, 128'h77000000000000000000000000000300);
        fork
            send_gic(1'b0, BP_BEATS, 128'h77000000000000000000000000000300);
            begin
                repeat (40) @(negedge OffClk);
                check_val({cur_test, "/full"}, '0, BEAT_W'(gic_in_rdy_o));
                off_rdy_en = 1'b1;
            end
        join
        wait_drain();
        finish_test();

        cur_test   = "patterns_random";
        rdy_random = 1'b1;
        run_patterns();
        wait_drain();
        rdy_random = 1'b0;
        finish_test();

        total_err += u_itf_top.u_itf_top_chk.fail_cnt;
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, total_err, u_itf_top.u_itf_top_chk.fail_cnt);
        if (total_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== itf_top_chk.sv ====
// --------------------
// Bound assertions on FIFO push/pop rules and pad enable
// --------------------
module itf_top_chk (
    input logic OffClk,
    input logic clk,
    input logic rst_n,
    input logic in_push_i,
    input logic in_full_i,
    input logic in_pop_i,
    input logic in_empty_i,
    input logic out_push_i,
    input logic out_full_i,
    input logic out_pop_i,
    input logic out_empty_i,
    input logic off_oe_i,
    input logic off_vld_i
);

    // Count of failed assertions
    int fail_cnt = 0;

    // --------------------
    // Inbound FIFO, written on OffClk
    in_push_ok: assert property (@(posedge OffClk) disable iff (!rst_n)
        in_push_i |-> !in_full_i)
        else begin
            fail_cnt++;
            $error("Inbound FIFO pushed while full");
        end

    in_pop_ok: assert property (@(posedge clk) disable iff (!rst_n)
        in_pop_i |-> !in_empty_i)
        else begin
            fail_cnt++;
            $error("Inbound FIFO popped while empty");
        end

    // --------------------
    // Outbound FIFO, written on clk
    out_push_ok: assert property (@(posedge clk) disable iff (!rst_n)
        out_push_i |-> !out_full_i)
        else begin
            fail_cnt++;
            $error("Outbound FIFO pushed while full");
        end

    out_pop_ok: assert property (@(posedge OffClk) disable iff (!rst_n)
        out_pop_i |-> !out_empty_i)
        else begin
            fail_cnt++;
            $error("Outbound FIFO popped while empty");
        end

    // Pads driven exactly with a valid beat
    oe_ok: assert property (@(posedge OffClk) disable iff (!rst_n)
        off_oe_i == off_vld_i)
        else begin
            fail_cnt++;
            $error("Output enable differs from outbound valid");
        end

endmodule

bind itf_top itf_top_chk u_itf_top_chk (
    .OffClk      (OffClk),
    .clk         (clk),
    .rst_n       (rst_n),
    .in_push_i   (in_push),
    .in_full_i   (in_full),
    .in_pop_i    (in_pop),
    .in_empty_i  (in_empty),
    .out_push_i  (out_push),
    .out_full_i  (out_full),
    .out_pop_i   (out_pop),
    .out_empty_i (out_empty),
    .off_oe_i    (off_oe_o),
    .off_vld_i   (off_dat_vld_o)
);

// ==== itf_top.sv ====
// --------------------
// Off-chip link bridge top, two controllers and two FIFOs
// --------------------
module itf_top
    import itf_cfg_pkg::*;
(
    input  logic             OffClk,
    input  logic             clk,
    input  logic             rst_n,
    // Off chip port
    input  logic             off_dat_vld_i,
    input  logic             off_dat_last_i,
    input  logic             off_isa_i,
    input  logic [DAT_W-1:0] off_dat_i,
    output logic             off_dat_rdy_o,
    output logic             off_dat_vld_o,
    output logic             off_dat_last_o,
    output logic             off_cmd_o,
    output logic [DAT_W-1:0] off_dat_o,
    output logic             off_oe_o,
    input  logic             off_dat_rdy_i,
    // CCU sink
    output logic [DAT_W-1:0] ccu_dat_o,
    output logic             ccu_vld_o,
    output logic             ccu_last_o,
    input  logic             ccu_rdy_i,
    // GIC sink
    output logic [DAT_W-1:0] gic_out_dat_o,
    output logic             gic_out_vld_o,
    output logic             gic_out_last_o,
    input  logic             gic_out_rdy_i,
    // GIC source
    input  logic [DAT_W-1:0] gic_in_dat_i,
    input  logic             gic_in_vld_i,
    input  logic             gic_in_last_i,
    input  logic             gic_in_cmd_i,
    output logic             gic_in_rdy_o,
    // MON source
    input  logic [DAT_W-1:0] mon_dat_i,
    input  logic             mon_vld_i,
    input  logic             mon_last_i,
    output logic             mon_rdy_o
);

    // Off chip to core FIFO
    logic              in_push;
    logic              in_pop;
    logic [BEAT_W-1:0] in_wr_beat;
    logic [BEAT_W-1:0] in_rd_beat;
    logic              in_empty;
    logic              in_full;

    // Core to off chip FIFO
    logic              out_push;
    logic              out_pop;
    logic [BEAT_W-1:0] out_wr_beat;
    logic [BEAT_W-1:0] out_rd_beat;
    logic              out_empty;
    logic              out_full;

    // --------------------
    // OffClk domain

    off_link_ctrl u_off_link_ctrl (
        .OffClk         (OffClk),
        .rst_n          (rst_n),
        .off_dat_vld_i  (off_dat_vld_i),
        .off_dat_last_i (off_dat_last_i),
        .off_isa_i      (off_isa_i),
        .off_dat_i      (off_dat_i),
        .off_dat_rdy_o  (off_dat_rdy_o),
        .off_dat_vld_o  (off_dat_vld_o),
        .off_dat_last_o (off_dat_last_o),
        .off_cmd_o      (off_cmd_o),
        .off_dat_o      (off_dat_o),
        .off_oe_o       (off_oe_o),
        .off_dat_rdy_i  (off_dat_rdy_i),
        .in_push_o      (in_push),
        .in_beat_o      (in_wr_beat),
        .in_full_i      (in_full),
        .out_pop_o      (out_pop),
        .out_beat_i     (out_rd_beat),
        .out_empty_i    (out_empty)
    );

    // --------------------
    // Core domain

    core_link_ctrl u_core_link_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_beat_i      (in_rd_beat),
        .in_empty_i     (in_empty),
        .in_pop_o       (in_pop),
        .ccu_dat_o      (ccu_dat_o),
        .ccu_vld_o      (ccu_vld_o),
        .ccu_last_o     (ccu_last_o),
        .ccu_rdy_i      (ccu_rdy_i),
        .gic_out_dat_o  (gic_out_dat_o),
        .gic_out_vld_o  (gic_out_vld_o),
        .gic_out_last_o (gic_out_last_o),
        .gic_out_rdy_i  (gic_out_rdy_i),
        .gic_in_dat_i   (gic_in_dat_i),
        .gic_in_vld_i   (gic_in_vld_i),
        .gic_in_last_i  (gic_in_last_i),
        .gic_in_cmd_i   (gic_in_cmd_i),
        .gic_in_rdy_o   (gic_in_rdy_o),
        .mon_dat_i      (mon_dat_i),
        .mon_vld_i      (mon_vld_i),
        .mon_last_i     (mon_last_i),
        .mon_rdy_o      (mon_rdy_o),
        .out_push_o     (out_push),
        .out_beat_o     (out_wr_beat),
        .out_full_i     (out_full)
    );

    // --------------------
    // Clock crossing

    // Written on OffClk, read on clk
    fifo_async_fwft #(
        .DATA_W (BEAT_W),
        .ADDR_W (FIFO_AW)
    ) u_fifo_in2chip (
        .rst_n    (rst_n),
        .wr_clk_i (OffClk),
        .rd_clk_i (clk),
        .push_i   (in_push),
        .pop_i    (in_pop),
        .data_i   (in_wr_beat),
        .data_o   (in_rd_beat),
        .empty_o  (in_empty),
        .full_o   (in_full)
    );

    // Written on clk, read on OffClk
    fifo_async_fwft #(
        .DATA_W (BEAT_W),
        .ADDR_W (FIFO_AW)
    ) u_fifo_out2off (
        .rst_n    (rst_n),
        .wr_clk_i (clk),
        .rd_clk_i (OffClk),
        .push_i   (out_push),
        .pop_i    (out_pop),
        .data_i   (out_wr_beat),
        .data_o   (out_rd_beat),
        .empty_o  (out_empty),
        .full_o   (out_full)
    );

endmodule

// ==== core_link_ctrl.sv ====
// --------------------
// Core side FSM, sink routing and outbound source select
// --------------------
module core_link_ctrl
    import itf_cfg_pkg::*;
    import itf_state_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Inbound FIFO read side
    input  logic [BEAT_W-1:0] in_beat_i,
    input  logic              in_empty_i,
    output logic              in_pop_o,
    // CCU sink
    output logic [DAT_W-1:0]  ccu_dat_o,
    output logic              ccu_vld_o,
    output logic              ccu_last_o,
    input  logic              ccu_rdy_i,
    // GIC sink
    output logic [DAT_W-1:0]  gic_out_dat_o,
    output logic              gic_out_vld_o,
    output logic              gic_out_last_o,
    input  logic              gic_out_rdy_i,
    // GIC source
    input  logic [DAT_W-1:0]  gic_in_dat_i,
    input  logic              gic_in_vld_i,
    input  logic              gic_in_last_i,
    input  logic              gic_in_cmd_i,
    output logic              gic_in_rdy_o,
    // MON source
    input  logic [DAT_W-1:0]  mon_dat_i,
    input  logic              mon_vld_i,
    input  logic              mon_last_i,
    output logic              mon_rdy_o,
    // Outbound FIFO write side
    output logic              out_push_o,
    output logic [BEAT_W-1:0] out_beat_o,
    input  logic              out_full_i
);

    link_state_e state_q;
    link_state_e state_d;

    // Outbound source held for a whole packet, 1 = MON
    logic src_mon_q;

    // Head entry of inbound FIFO
    logic             head_vld;
    logic             head_isa;
    logic             head_last;
    logic [DAT_W-1:0] head_dat;

    logic gic_in_hs;
    logic mon_hs;

    // --------------------
    // FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            LINK_IDLE: begin
                if (!in_empty_i) begin
                    state_d = LINK_IN2CHIP;
                end else if (gic_in_vld_i || mon_vld_i) begin
                    state_d = LINK_OUT2OFF;
                end
            end
            // Leave on last beat taken by a sink
            LINK_IN2CHIP: begin
                if (in_pop_o && head_last) begin
                    state_d = LINK_IDLE;
                end
            end
            LINK_OUT2OFF: begin
                if ((gic_in_hs && gic_in_last_i) || (mon_hs && mon_last_i)) begin
                    state_d = LINK_IDLE;
                end
            end
            default: state_d = LINK_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= LINK_IDLE;
            src_mon_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // MON wins only at packet start
            if (state_q == LINK_IDLE && state_d == LINK_OUT2OFF) begin
                src_mon_q <= mon_vld_i;
            end
        end
    end

    // --------------------
    // Inbound routing

    assign head_vld  = (state_q == LINK_IN2CHIP) & ~in_empty_i;
    assign head_isa  = in_beat_i[BEAT_FLAG_BIT];
    assign head_last = in_beat_i[BEAT_LAST_BIT];
    assign head_dat  = in_beat_i[BEAT_W-1 -: DAT_W];

    // Instruction beats to CCU, rest to GIC
    assign ccu_vld_o      = head_vld & head_isa;
    assign ccu_last_o     = ccu_vld_o & head_last;
    assign ccu_dat_o      = ccu_vld_o ? head_dat : '0;
    assign gic_out_vld_o  = head_vld & ~head_isa;
    assign gic_out_last_o = gic_out_vld_o & head_last;
    assign gic_out_dat_o  = gic_out_vld_o ? head_dat : '0;

    assign in_pop_o = (ccu_vld_o & ccu_rdy_i) | (gic_out_vld_o & gic_out_rdy_i);

    // --------------------
    // Outbound select

    // Ready only to the held source
    assign mon_rdy_o    = (state_q == LINK_OUT2OFF) & src_mon_q & ~out_full_i;
    assign gic_in_rdy_o = (state_q == LINK_OUT2OFF) & ~src_mon_q & ~out_full_i;

    assign mon_hs    = mon_vld_i & mon_rdy_o;
    assign gic_in_hs = gic_in_vld_i & gic_in_rdy_o;

    assign out_push_o = mon_hs | gic_in_hs;

    // MON beats never carry a command flag
    assign out_beat_o = src_mon_q ? {mon_dat_i, 1'b0, mon_last_i}
                                  : {gic_in_dat_i, gic_in_cmd_i, gic_in_last_i};

endmodule

// ==== off_link_ctrl.sv ====
// --------------------
// OffClk side FSM, inbound FIFO push and outbound FIFO pop
// --------------------
module off_link_ctrl
    import itf_cfg_pkg::*;
    import itf_state_pkg::*;
(
    input  logic              OffClk,
    input  logic              rst_n,
    // Off chip to core
    input  logic              off_dat_vld_i,
    input  logic              off_dat_last_i,
    input  logic              off_isa_i,
    input  logic [DAT_W-1:0]  off_dat_i,
    output logic              off_dat_rdy_o,
    // Core to off chip
    output logic              off_dat_vld_o,
    output logic              off_dat_last_o,
    output logic              off_cmd_o,
    output logic [DAT_W-1:0]  off_dat_o,
    output logic              off_oe_o,
    input  logic              off_dat_rdy_i,
    // Inbound FIFO write side
    output logic              in_push_o,
    output logic [BEAT_W-1:0] in_beat_o,
    input  logic              in_full_i,
    // Outbound FIFO read side
    output logic              out_pop_o,
    input  logic [BEAT_W-1:0] out_beat_i,
    input  logic              out_empty_i
);

    link_state_e state_q;
    link_state_e state_d;

    // --------------------
    // FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Inbound first, outbound only when off chip is quiet
            LINK_IDLE: begin
                if (off_dat_vld_i) begin
                    state_d = LINK_IN2CHIP;
                end else if (!out_empty_i) begin
                    state_d = LINK_OUT2OFF;
                end
            end
            LINK_IN2CHIP: begin
                if (in_push_o && off_dat_last_i) begin
                    state_d = LINK_IDLE;
                end
            end
            LINK_OUT2OFF: begin
                if (out_pop_o && off_dat_last_o) begin
                    state_d = LINK_IDLE;
                end
            end
            default: state_d = LINK_IDLE;
        endcase
    end

    always_ff @(posedge OffClk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LINK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Inbound push

    // Accept only while room left
    assign off_dat_rdy_o = (state_q == LINK_IN2CHIP) & ~in_full_i;
    assign in_push_o     = off_dat_vld_i & off_dat_rdy_o;

    always_comb begin
        in_beat_o                        = '0;
        in_beat_o[BEAT_W-1 -: DAT_W]     = off_dat_i;
        in_beat_o[BEAT_FLAG_BIT]         = off_isa_i;
        in_beat_o[BEAT_LAST_BIT]         = off_dat_last_i;
    end

    // --------------------
    // Outbound pop

    assign off_dat_vld_o = (state_q == LINK_OUT2OFF) & ~out_empty_i;
    // Drive pads only with a valid beat
    assign off_oe_o      = off_dat_vld_o;
    assign out_pop_o     = off_dat_vld_o & off_dat_rdy_i;

    // Fields held at 0 outside outbound
    always_comb begin
        off_dat_o      = '0;
        off_cmd_o      = 1'b0;
        off_dat_last_o = 1'b0;
        if (state_q == LINK_OUT2OFF) begin
            off_dat_o      = out_beat_i[BEAT_W-1 -: DAT_W];
            off_cmd_o      = out_beat_i[BEAT_FLAG_BIT];
            off_dat_last_o = out_beat_i[BEAT_LAST_BIT];
        end
    end

endmodule

// ==== fifo_async_fwft.sv ====
// --------------------
// Dual-clock FIFO, gray pointers, first-word-fall-through read
// --------------------
module fifo_async_fwft #(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 4
) (
    input  logic              rst_n,
    input  logic              wr_clk_i,
    input  logic              rd_clk_i,
    input  logic              push_i,
    input  logic              pop_i,
    input  logic [DATA_W-1:0] data_i,
    output logic [DATA_W-1:0] data_o,
    output logic              empty_o,
    output logic              full_o
);

    // Storage, no reset
    logic [DATA_W-1:0] mem [(1 << ADDR_W)];

    // Pointers carry one wrap bit above the address
    logic [ADDR_W:0] wr_bin_q;
    logic [ADDR_W:0] wr_bin_d;
    logic [ADDR_W:0] wr_gray_q;
    logic [ADDR_W:0] rd_bin_q;
    logic [ADDR_W:0] rd_bin_d;
    logic [ADDR_W:0] rd_gray_q;

    // Gray pointers after crossing
    logic [ADDR_W:0] wr_gray_s1;
    logic [ADDR_W:0] wr_gray_s2;
    logic [ADDR_W:0] rd_gray_s1;
    logic [ADDR_W:0] rd_gray_s2;

    logic wr_en;
    logic rd_en;

    // --------------------
    // Write side

    // Push ignored when full
    assign wr_en    = push_i & ~full_o;
    assign wr_bin_d = wr_bin_q + {{ADDR_W{1'b0}}, wr_en};

    always_ff @(posedge wr_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
        end else begin
            wr_bin_q  <= wr_bin_d;
            wr_gray_q <= wr_bin_d ^ (wr_bin_d >> 1);
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (wr_en) begin
            mem[wr_bin_q[ADDR_W-1:0]] <= data_i;
        end
    end

    // Read pointer into write domain
    always_ff @(posedge wr_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray_q;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // Full when writer is one lap ahead, top two gray bits inverted
    assign full_o = (wr_gray_q == {~rd_gray_s2[ADDR_W:ADDR_W-1], rd_gray_s2[ADDR_W-2:0]});

    // --------------------
    // Read side

    // Pop ignored when empty
    assign rd_en    = pop_i & ~empty_o;
    assign rd_bin_d = rd_bin_q + {{ADDR_W{1'b0}}, rd_en};

    always_ff @(posedge rd_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
        end else begin
            rd_bin_q  <= rd_bin_d;
            rd_gray_q <= rd_bin_d ^ (rd_bin_d >> 1);
        end
    end

    // Write pointer into read domain
    always_ff @(posedge rd_clk_i or negedge rst_n) begin
        if (!rst_n) begin
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray_q;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    assign empty_o = (rd_gray_q == wr_gray_s2);

    // Head entry always visible
    assign data_o = mem[rd_bin_q[ADDR_W-1:0]];

endmodule

// ==== itf_state_pkg.sv ====
// --------------------
// Link direction state shared by both domain FSMs
// --------------------
package itf_state_pkg;

    // Idle, off chip to core, core to off chip
    typedef enum logic [1:0] {
        LINK_IDLE    = 2'd0,
        LINK_IN2CHIP = 2'd1,
        LINK_OUT2OFF = 2'd2
    } link_state_e;

    // Value 3 unused
    // Both FSMs fall back to idle on it

endpackage

// ==== itf_cfg_pkg.sv ====
// --------------------
// Link widths, FIFO depth and beat field layout
// --------------------
package itf_cfg_pkg;

    // Payload carried on the off-chip data port
    localparam int DAT_W = 128;

    // --------------------
    // FIFO entry layout

    // Entry = {payload, flag, last}
    localparam int BEAT_W = DAT_W + 2;

    // Last beat of a packet
    localparam int BEAT_LAST_BIT = 0;
    // Instruction flag inbound, command flag outbound
    localparam int BEAT_FLAG_BIT = 1;

    // --------------------
    // Clock crossing FIFOs

    // 16 entries per direction
    localparam int FIFO_AW = 4;

endpackage
